// File: rtl/fec_params.svh
// Widths, register map, response codes and CRC settings for the FEC downlink
`ifndef FEC_PARAMS_SVH
`define FEC_PARAMS_SVH

// Message and frame geometry
`define FEC_MSG_BYTES    8
`define FEC_MSG_W        64
`define FEC_FRAME_W      88
`define FEC_CRC_W        8
// CRC-8 x^8+x^2+x+1, zero init, MSB first
`define FEC_CRC_POLY     8'h07
// Leading frame bits covered by the error mask
`define FEC_ERR_SPAN     32
`define FEC_DIV_W        8

// AXI4-Lite bus
`define FEC_AXI_AW       8
`define FEC_AXI_DW       32

// Register map
`define FEC_REG_CTRL     8'h00
`define FEC_REG_STATUS   8'h04
`define FEC_REG_MSG_LO   8'h08
`define FEC_REG_MSG_HI   8'h0C
`define FEC_REG_DIV      8'h10
`define FEC_REG_ERR_MASK 8'h14

`define FEC_RESP_OKAY    2'd0
`define FEC_RESP_SLVERR  2'd2

`endif

// File: rtl/fec_pkg.sv
// Package fec_pkg with AXI4-Lite channel, frame and downlink config struct types
`default_nettype none

`include "fec_params.svh"

package fec_pkg;

  // Master-driven AXI4-Lite channels, full-word writes only
  typedef struct packed {
    logic                   awvalid;
    logic [`FEC_AXI_AW-1:0] awaddr;
    logic                   wvalid;
    logic [`FEC_AXI_DW-1:0] wdata;
    logic                   bready;
    logic                   arvalid;
    logic [`FEC_AXI_AW-1:0] araddr;
    logic                   rready;
  } axil_req_t;

  // Slave-driven AXI4-Lite channels
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [`FEC_AXI_DW-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

  // Frame goes out MSB first, byte 0 in the top msg bits
  typedef struct packed {
    logic [`FEC_MSG_W-1:0]     msg;
    logic [`FEC_MSG_BYTES-1:0] row_par;
    logic [7:0]                col_par;
    logic [`FEC_CRC_W-1:0]     crc;
  } fec_frame_t;

  // Downlink settings from the register file
  typedef struct packed {
    logic [`FEC_DIV_W-1:0]    clk_div;
    logic [`FEC_ERR_SPAN-1:0] err_mask;
    logic                     err_en;
  } dl_cfg_t;

endpackage

`default_nettype wire

// File: rtl/fec_axil_regs.sv
// Module fec_axil_regs: AXI4-Lite slave, register file, start and error-injection control
`timescale 1ns/1ps
`default_nettype none

`include "fec_params.svh"

module fec_axil_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fec_pkg::axil_req_t    axil_req,
  output fec_pkg::axil_rsp_t    axil_rsp,
  input  logic                  enc_busy,
  input  logic                  tx_busy,
  input  logic                  frame_done,
  output logic [`FEC_MSG_W-1:0] msg,
  output logic                  start,
  output fec_pkg::dl_cfg_t      dl_cfg,
  output logic                  dl_ready
);
  import fec_pkg::*;

  // Handshake state
  logic                      wr_rdy_q;
  logic                      bvalid_q;
  logic [1:0]                bresp_q;
  logic                      arready_q;
  logic                      rvalid_q;
  logic [`FEC_AXI_DW-1:0]    rdata_q;
  logic [1:0]                rresp_q;
  // Register file
  logic [`FEC_AXI_DW-1:0]    msg_lo_q;
  logic [`FEC_AXI_DW-1:0]    msg_hi_q;
  logic [`FEC_DIV_W-1:0]     div_q;
  logic [`FEC_ERR_SPAN-1:0]  mask_q;
  logic                      err_en_q;
  logic                      busy_q;
  logic                      start_q;
  logic [7:0]                frame_cnt_q;
  // Decode
  logic                      wr_fire;
  logic                      rd_fire;
  logic                      busy_any;
  logic                      wr_err;
  logic                      rd_err;
  logic [`FEC_AXI_DW-1:0]    rd_data;

  assign wr_fire  = axil_req.awvalid & axil_req.wvalid & wr_rdy_q;
  assign rd_fire  = axil_req.arvalid & arready_q;
  // Any stage of the downlink still holding a frame
  assign busy_any = busy_q | start_q | enc_busy | tx_busy;

  // Write decode, start while busy is refused
  always_comb begin
    wr_err = 1'b0;
    case (axil_req.awaddr)
      `FEC_REG_CTRL:     wr_err = axil_req.wdata[0] & busy_any;
      `FEC_REG_STATUS,
      `FEC_REG_MSG_LO,
      `FEC_REG_MSG_HI,
      `FEC_REG_DIV,
      `FEC_REG_ERR_MASK: wr_err = 1'b0;
      default:           wr_err = 1'b1;
    endcase
  end

  // Read decode, unmapped reads give zero
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (axil_req.araddr)
      `FEC_REG_CTRL:     rd_data[1] = err_en_q;
      `FEC_REG_STATUS: begin
        rd_data[0]    = busy_any;
        rd_data[1]    = err_en_q;
        rd_data[15:8] = frame_cnt_q;
      end
      `FEC_REG_MSG_LO:   rd_data = msg_lo_q;
      `FEC_REG_MSG_HI:   rd_data = msg_hi_q;
      `FEC_REG_DIV:      rd_data[`FEC_DIV_W-1:0] = div_q;
      `FEC_REG_ERR_MASK: rd_data = mask_q;
      default:           rd_err = 1'b1;
    endcase
  end

  // AXI4-Lite handshakes, one outstanding transfer per direction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_rdy_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      bresp_q   <= `FEC_RESP_OKAY;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rdata_q   <= '0;
      rresp_q   <= `FEC_RESP_OKAY;
    end else begin
      // Ready pulse for a single cycle
      wr_rdy_q  <= axil_req.awvalid & axil_req.wvalid & ~bvalid_q & ~wr_rdy_q;
      arready_q <= axil_req.arvalid & ~rvalid_q & ~arready_q;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_err ? `FEC_RESP_SLVERR : `FEC_RESP_OKAY;
      end else if (bvalid_q && axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      // Read data held stable until rready
      if (rd_fire) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rd_data;
        rresp_q  <= rd_err ? `FEC_RESP_SLVERR : `FEC_RESP_OKAY;
      end else if (rvalid_q && axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Register file and frame control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      msg_lo_q    <= '0;
      msg_hi_q    <= '0;
      div_q       <= '0;
      mask_q      <= '0;
      err_en_q    <= 1'b0;
      busy_q      <= 1'b0;
      start_q     <= 1'b0;
      frame_cnt_q <= '0;
    end else begin
      start_q <= wr_fire & ~wr_err & (axil_req.awaddr == `FEC_REG_CTRL) & axil_req.wdata[0];
      if (start_q) begin
        busy_q <= 1'b1;
      end else if (frame_done) begin
        busy_q <= 1'b0;
      end
      if (frame_done) begin
        frame_cnt_q <= frame_cnt_q + 8'd1;
        // Injection is one-shot
        err_en_q    <= 1'b0;
      end
      // Host writes override the disarm
      if (wr_fire && !wr_err) begin
        case (axil_req.awaddr)
          `FEC_REG_CTRL: begin
            if (axil_req.wdata[1]) begin
              err_en_q <= 1'b1;
            end
          end
          `FEC_REG_MSG_LO:   msg_lo_q <= axil_req.wdata;
          `FEC_REG_MSG_HI:   msg_hi_q <= axil_req.wdata;
          `FEC_REG_DIV:      div_q    <= axil_req.wdata[`FEC_DIV_W-1:0];
          `FEC_REG_ERR_MASK: mask_q   <= axil_req.wdata;
          default: ;
        endcase
      end
    end
  end

  // Response channels
  assign axil_rsp.awready = wr_rdy_q;
  assign axil_rsp.wready  = wr_rdy_q;
  assign axil_rsp.bvalid  = bvalid_q;
  assign axil_rsp.bresp   = bresp_q;
  assign axil_rsp.arready = arready_q;
  assign axil_rsp.rvalid  = rvalid_q;
  assign axil_rsp.rdata   = rdata_q;
  assign axil_rsp.rresp   = rresp_q;

  // Byte 0 sits in msg[7:0]
  assign msg      = {msg_hi_q, msg_lo_q};
  assign start    = start_q;
  assign dl_cfg   = '{clk_div: div_q, err_mask: mask_q, err_en: err_en_q};
  assign dl_ready = ~busy_q;

endmodule

`default_nettype wire

// File: rtl/fec_encoder.sv
// Module fec_encoder: bit-serial CRC-8, row parity and column parity over an 8-byte message
`timescale 1ns/1ps
`default_nettype none

`include "fec_params.svh"

module fec_encoder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`FEC_MSG_W-1:0] msg,
  input  logic                  start,
  output fec_pkg::fec_frame_t   frame,
  output logic                  frame_valid,
  output logic                  enc_busy
);
  import fec_pkg::*;

  localparam int BYTE_W = 8;
  localparam int BIT_W  = $clog2(BYTE_W);
  localparam int CNT_W  = $clog2(`FEC_MSG_W);

  logic [`FEC_MSG_W-1:0]     msg_ord;
  logic [`FEC_MSG_W-1:0]     src;
  logic [`FEC_MSG_W-1:0]     shift_q;
  logic [`FEC_CRC_W-1:0]     crc_q;
  logic [`FEC_CRC_W-1:0]     crc_in;
  logic [`FEC_CRC_W-1:0]     crc_nxt;
  logic [`FEC_MSG_BYTES-1:0] row_q;
  logic [`FEC_MSG_BYTES-1:0] row_in;
  logic [`FEC_MSG_BYTES-1:0] row_nxt;
  logic [BYTE_W-1:0]         col_q;
  logic [BYTE_W-1:0]         col_in;
  logic [BYTE_W-1:0]         col_nxt;
  logic                      row_acc_q;
  logic                      row_acc_in;
  logic                      row_acc_nxt;
  logic [CNT_W-1:0]          cnt_q;
  logic [CNT_W-1:0]          cnt_in;
  logic                      run_q;
  logic                      step;
  logic                      bit_in;
  logic                      fb;

  // Transmit order, byte 0 on top
  always_comb begin
    for (int i = 0; i < `FEC_MSG_BYTES; i++) begin
      msg_ord[`FEC_MSG_W-1-BYTE_W*i -: BYTE_W] = msg[BYTE_W*i +: BYTE_W];
    end
  end

  // One message bit per step, start cycle handles bit 0 from fresh state
  always_comb begin
    src        = start ? msg_ord : shift_q;
    crc_in     = start ? '0 : crc_q;
    row_in     = start ? '0 : row_q;
    col_in     = start ? '0 : col_q;
    row_acc_in = start ? 1'b0 : row_acc_q;
    cnt_in     = start ? '0 : cnt_q;
    bit_in     = src[`FEC_MSG_W-1];
    // CRC shift with feedback
    fb         = crc_in[`FEC_CRC_W-1] ^ bit_in;
    crc_nxt    = {crc_in[`FEC_CRC_W-2:0], 1'b0} ^ ({`FEC_CRC_W{fb}} & `FEC_CRC_POLY);
    // Column parity per bit position in the byte
    col_nxt    = col_in;
    col_nxt[BYTE_W-1-cnt_in[BIT_W-1:0]] = col_in[BYTE_W-1-cnt_in[BIT_W-1:0]] ^ bit_in;
    // Row parity shifted in per byte, byte 0 ends in the MSB
    if (cnt_in[BIT_W-1:0] == BIT_W'(BYTE_W-1)) begin
      row_nxt     = {row_in[`FEC_MSG_BYTES-2:0], row_acc_in ^ bit_in};
      row_acc_nxt = 1'b0;
    end else begin
      row_nxt     = row_in;
      row_acc_nxt = row_acc_in ^ bit_in;
    end
  end

  assign step = start | run_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q       <= 1'b0;
      cnt_q       <= '0;
      frame_valid <= 1'b0;
    end else begin
      if (start) begin
        run_q <= 1'b1;
      end else if (run_q && cnt_q == CNT_W'(`FEC_MSG_W-1)) begin
        run_q <= 1'b0;
      end
      if (step) begin
        cnt_q <= cnt_in + 1'b1;
      end
      // Last bit lands 64 cycles after start
      frame_valid <= run_q && (cnt_q == CNT_W'(`FEC_MSG_W-1));
    end
  end

  // Rotating register gives the message back after 64 steps
  always_ff @(posedge clk) begin
    if (step) begin
      shift_q   <= {src[`FEC_MSG_W-2:0], src[`FEC_MSG_W-1]};
      crc_q     <= crc_nxt;
      row_q     <= row_nxt;
      col_q     <= col_nxt;
      row_acc_q <= row_acc_nxt;
    end
  end

  assign frame    = '{msg: shift_q, row_par: row_q, col_par: col_q, crc: crc_q};
  assign enc_busy = run_q | frame_valid;

endmodule

`default_nettype wire

// File: rtl/dl_serializer.sv
// Module dl_serializer: divided-rate frame shifter with one-shot error injection
`timescale 1ns/1ps
`default_nettype none

`include "fec_params.svh"

module dl_serializer (
  input  logic                clk,
  input  logic                rst_n,
  input  fec_pkg::fec_frame_t frame,
  input  logic                frame_valid,
  input  fec_pkg::dl_cfg_t    dl_cfg,
  output logic                dl_out,
  output logic                dl_en,
  output logic                tx_busy,
  output logic                frame_done
);
  import fec_pkg::*;

  localparam int BIT_CNT_W = $clog2(`FEC_FRAME_W);

  logic [`FEC_FRAME_W-1:0] sh_q;
  logic [`FEC_FRAME_W-1:0] inj_vec;
  logic [`FEC_DIV_W-1:0]   div_q;
  logic [`FEC_DIV_W-1:0]   div_cnt_q;
  logic [BIT_CNT_W-1:0]    bit_cnt_q;
  logic                    en_q;
  logic                    group_end;
  logic                    last_bit;

  // Mask covers the leading bits only when armed
  assign inj_vec = {{`FEC_ERR_SPAN{dl_cfg.err_en}} & dl_cfg.err_mask,
                    {(`FEC_FRAME_W-`FEC_ERR_SPAN){1'b0}}};

  // Bit group is clk_div + 1 cycles
  assign group_end = (div_cnt_q == div_q);
  assign last_bit  = (bit_cnt_q == BIT_CNT_W'(`FEC_FRAME_W-1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q       <= 1'b0;
      div_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= en_q & group_end & last_bit;
      if (frame_valid) begin
        en_q      <= 1'b1;
        div_cnt_q <= '0;
        bit_cnt_q <= '0;
      end else if (en_q && group_end) begin
        div_cnt_q <= '0;
        if (last_bit) begin
          en_q <= 1'b0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else if (en_q) begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

  // Frame and divider captured at frame_valid
  always_ff @(posedge clk) begin
    if (frame_valid) begin
      sh_q  <= frame ^ inj_vec;
      div_q <= dl_cfg.clk_div;
    end else if (en_q && group_end) begin
      sh_q  <= {sh_q[`FEC_FRAME_W-2:0], 1'b0};
    end
  end

  // MSB first
  assign dl_out  = en_q & sh_q[`FEC_FRAME_W-1];
  assign dl_en   = en_q;
  assign tx_busy = en_q;

endmodule

`default_nettype wire

// File: rtl/fec_top.sv
// Module fec_top: register slave, encoder and downlink serializer
`timescale 1ns/1ps
`default_nettype none

`include "fec_params.svh"

module fec_top (
  input  logic               clk,
  input  logic               rst_n,
  input  fec_pkg::axil_req_t axil_req,
  output fec_pkg::axil_rsp_t axil_rsp,
  output logic               dl_out,
  output logic               dl_en,
  output logic               dl_ready
);
  import fec_pkg::*;

  // Register file to encoder
  logic [`FEC_MSG_W-1:0] msg;
  logic                  start;
  logic                  enc_busy;
  // Encoder to serializer
  fec_frame_t            frame;
  logic                  frame_valid;
  // Serializer settings and status
  dl_cfg_t               dl_cfg;
  logic                  tx_busy;
  logic                  frame_done;

  fec_axil_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .enc_busy   (enc_busy),
    .tx_busy    (tx_busy),
    .frame_done (frame_done),
    .msg        (msg),
    .start      (start),
    .dl_cfg     (dl_cfg),
    .dl_ready   (dl_ready)
  );

  fec_encoder u_enc (
    .clk         (clk),
    .rst_n       (rst_n),
    .msg         (msg),
    .start       (start),
    .frame       (frame),
    .frame_valid (frame_valid),
    .enc_busy    (enc_busy)
  );

  dl_serializer u_ser (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .dl_cfg      (dl_cfg),
    .dl_out      (dl_out),
    .dl_en       (dl_en),
    .tx_busy     (tx_busy),
    .frame_done  (frame_done)
  );

endmodule

`default_nettype wire

// File: test/fec_tb_tasks.svh
// AXI4-Lite master tasks, reference frame model, value check and failure stop for tb_fec_top
`ifndef FEC_TB_TASKS_SVH
`define FEC_TB_TASKS_SVH

localparam int DRIVE_DLY   = 2;
localparam int AXI_TIMEOUT = 50;

task automatic stop_with_error(input string what);
  $display("%s", what);
  $display("Some tests failed");
  $fatal(1, "Run stopped");
endtask

task automatic check_eq(input string name, input logic [`FEC_FRAME_W-1:0] got,
                        input logic [`FEC_FRAME_W-1:0] exp);
  if (got !== exp) begin
    stop_with_error($sformatf("Mismatch at %0t ns: %s got 0x%0h, expected 0x%0h",
                              $time, name, got, exp));
  end
endtask

// Full-word write returning bresp
task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                         output logic [1:0] resp);
  int n;
  @(posedge clk);
  #DRIVE_DLY;
  req.awvalid = 1'b1;
  req.awaddr  = addr;
  req.wvalid  = 1'b1;
  req.wdata   = data;
  req.bready  = 1'b1;
  n = 0;
  @(posedge clk);
  while (!rsp.awready) begin
    n++;
    if (n > AXI_TIMEOUT) stop_with_error("AXI write address and data were never accepted");
    @(posedge clk);
  end
  // Data channel accepted together with the address
  check_eq("wready", rsp.wready, 1'b1);
  #DRIVE_DLY;
  req.awvalid = 1'b0;
  req.wvalid  = 1'b0;
  // Response one cycle after the ready pulse
  n = 0;
  @(posedge clk);
  while (!rsp.bvalid) begin
    n++;
    if (n > AXI_TIMEOUT) stop_with_error("AXI write response never arrived");
    @(posedge clk);
  end
  resp = rsp.bresp;
  #DRIVE_DLY;
  req.bready = 1'b0;
endtask

task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
  int n;
  @(posedge clk);
  #DRIVE_DLY;
  req.arvalid = 1'b1;
  req.araddr  = addr;
  req.rready  = 1'b1;
  n = 0;
  @(posedge clk);
  while (!rsp.arready) begin
    n++;
    if (n > AXI_TIMEOUT) stop_with_error("AXI read address was never accepted");
    @(posedge clk);
  end
  #DRIVE_DLY;
  req.arvalid = 1'b0;
  n = 0;
  @(posedge clk);
  while (!rsp.rvalid) begin
    n++;
    if (n > AXI_TIMEOUT) stop_with_error("AXI read data never arrived");
    @(posedge clk);
  end
  data = rsp.rdata;
  resp = rsp.rresp;
  #DRIVE_DLY;
  req.rready = 1'b0;
endtask

task automatic write_ok(input logic [7:0] addr, input logic [31:0] data, input string name);
  logic [1:0] resp;
  axi_write(addr, data, resp);
  check_eq({name, " bresp"}, resp, `FEC_RESP_OKAY);
endtask

task automatic read_check(input logic [7:0] addr, input logic [31:0] exp,
                          input logic [1:0] exp_resp, input string name);
  logic [31:0] data;
  logic [1:0]  resp;
  axi_read(addr, data, resp);
  check_eq({name, " rdata"}, data, exp);
  check_eq({name, " rresp"}, resp, exp_resp);
endtask

// Expected frame in send order with row parity, column parity and CRC-8
function automatic logic [`FEC_FRAME_W-1:0] model_frame(input logic [`FEC_MSG_W-1:0] m);
  logic [7:0]            b;
  logic [`FEC_MSG_W-1:0] ord;
  logic [7:0]            row;
  logic [7:0]            col;
  logic [7:0]            crc;
  ord = '0;
  row = '0;
  col = '0;
  crc = '0;
  for (int i = 0; i < `FEC_MSG_BYTES; i++) begin
    b = m[8*i +: 8];
    ord[`FEC_MSG_W-1-8*i -: 8] = b;
    // Byte 0 parity lands in the row MSB
    row[7-i] = ^b;
    col      = col ^ b;
    // Bytewise CRC shifted MSB first
    crc = crc ^ b;
    for (int j = 0; j < 8; j++) begin
      crc = crc[7] ? ((crc << 1) ^ `FEC_CRC_POLY) : (crc << 1);
    end
  end
  return {ord, row, col, crc};
endfunction

`endif

// File: test/tb_fec_top.sv
// Testbench tb_fec_top: clock, reset, random register traffic and downlink frame capture
`timescale 1ns/1ps
`default_nettype none

`include "fec_params.svh"

module tb_fec_top;
  import fec_pkg::*;

  localparam int FRAME_TIMEOUT = 200;
  localparam int READY_TIMEOUT = 500;
  localparam int ITERATIONS    = 12;

  logic                    clk;
  logic                    rst_n;
  axil_req_t               req;
  axil_rsp_t               rsp;
  logic                    dl_out;
  logic                    dl_en;
  logic                    dl_ready;
  // Stimulus and model state
  logic [31:0]             seed_ret;
  logic [`FEC_MSG_W-1:0]   m;
  logic [31:0]             mask;
  int                      div;
  logic                    arm;
  logic                    prev_arm;
  logic [`FEC_FRAME_W-1:0] exp_f;
  logic [`FEC_FRAME_W-1:0] got_f;
  int                      len;
  int                      frames;
  logic [1:0]              resp;

  `include "fec_tb_tasks.svh"

  fec_top i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (req),
    .axil_rsp (rsp),
    .dl_out   (dl_out),
    .dl_en    (dl_en),
    .dl_ready (dl_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic wait_dl_ready(input logic level, input string what);
    int n;
    n = 0;
    @(posedge clk);
    while (dl_ready !== level) begin
      n++;
      if (n > READY_TIMEOUT) stop_with_error(what);
      @(posedge clk);
    end
  endtask

  // Samples each bit mid-group and counts dl_en cycles
  task automatic capture_frame(input int d, output logic [`FEC_FRAME_W-1:0] bits,
                               output int n);
    int w;
    bits = '0;
    w    = 0;
    @(posedge clk);
    while (!dl_en) begin
      w++;
      if (w > FRAME_TIMEOUT) stop_with_error("Downlink frame never started");
      @(posedge clk);
    end
    n = 0;
    while (dl_en) begin
      if ((n % (d + 1)) == d / 2 && n / (d + 1) < `FEC_FRAME_W) begin
        bits[`FEC_FRAME_W-1-n/(d+1)] = dl_out;
      end
      n++;
      if (n > `FEC_FRAME_W * (d + 1) + 16) stop_with_error("dl_en stayed high too long");
      @(posedge clk);
    end
  endtask

  initial begin
    seed_ret = $urandom(32'h727605e5);
    req      = '0;
    rst_n    = 1'b0;
    repeat (16) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    check_eq("dl_ready after reset", dl_ready, 1'b1);
    check_eq("dl_en after reset", dl_en, 1'b0);
    // Unmapped address
    read_check(8'h3C, 32'h0, `FEC_RESP_SLVERR, "unmapped");
    frames   = 0;
    prev_arm = 1'b0;
    for (int it = 0; it < ITERATIONS; it++) begin
      m    = {$urandom, $urandom};
      mask = $urandom;
      div  = $urandom_range(3, 0);
      // A clean frame always follows an injected one
      arm  = ($urandom_range(1, 0) == 1) && !prev_arm;
      write_ok(`FEC_REG_MSG_LO, m[31:0], "MSG_LO");
      write_ok(`FEC_REG_MSG_HI, m[63:32], "MSG_HI");
      write_ok(`FEC_REG_DIV, 32'(div), "DIV");
      write_ok(`FEC_REG_ERR_MASK, mask, "ERR_MASK");
      read_check(`FEC_REG_MSG_LO, m[31:0], `FEC_RESP_OKAY, "MSG_LO");
      read_check(`FEC_REG_MSG_HI, m[63:32], `FEC_RESP_OKAY, "MSG_HI");
      read_check(`FEC_REG_DIV, 32'(div), `FEC_RESP_OKAY, "DIV");
      read_check(`FEC_REG_ERR_MASK, mask, `FEC_RESP_OKAY, "ERR_MASK");
      exp_f = model_frame(m);
      if (arm) begin
        exp_f = exp_f ^ {mask, {(`FEC_FRAME_W-`FEC_ERR_SPAN){1'b0}}};
      end
      write_ok(`FEC_REG_CTRL, {30'b0, arm, 1'b1}, "CTRL start");
      wait_dl_ready(1'b0, "dl_ready did not fall after start");
      // Second start while busy is refused
      axi_write(`FEC_REG_CTRL, 32'h1, resp);
      check_eq("CTRL busy start bresp", resp, `FEC_RESP_SLVERR);
      // Busy with the armed bit still set while the frame is in flight
      read_check(`FEC_REG_STATUS, {16'b0, frames[7:0], 6'b0, arm, 1'b1}, `FEC_RESP_OKAY,
                 "STATUS busy");
      capture_frame(div, got_f, len);
      frames++;
      check_eq("dl_out frame", got_f, exp_f);
      check_eq("dl_en length", len, `FEC_FRAME_W * (div + 1));
      wait_dl_ready(1'b1, "dl_ready did not rise after the frame");
      // Idle and disarmed with the count of captured frames
      read_check(`FEC_REG_STATUS, {16'b0, frames[7:0], 8'b0}, `FEC_RESP_OKAY, "STATUS");
      prev_arm = arm;
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+rtl
+incdir+test
rtl/fec_pkg.sv
rtl/fec_axil_regs.sv
rtl/fec_encoder.sv
rtl/dl_serializer.sv
rtl/fec_top.sv
test/tb_fec_top.sv
